//--- periph_subsystem.f
source/periph_pkg.sv
source/axil_to_req.sv
source/region_router.sv
source/boot_ram.sv
source/gpio_regs.sv
source/periph_subsystem.sv
dv/periph_subsystem_chk.sv
dv/tb_periph_subsystem.sv

//--- Makefile
# Verilator build and run for the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_subsystem
FILELIST  ?= periph_subsystem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Passes only when the pass message shows up in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/tb_periph_subsystem.sv
// Testbench for the peripheral subsystem
// AXI4-Lite write and read driver tasks with per-wait timeouts
// Boot RAM, GPIO, error region and back-pressure stimulus with immediate checks
`timescale 1ns/1ps
`default_nettype none

module tb_periph_subsystem;

    localparam int TIMEOUT = 50; // Cycles allowed for any single wait

    logic        clk;
    logic        reset;
    logic [15:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [15:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [7:0]  leds;
    logic [7:0]  dip_switches;

    int          seed = 32'hc2c7;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic [31:0] ram_model [256];   // Expected boot RAM contents

    periph_subsystem i_periph_subsystem (
        .clk_i          (clk),
        .reset_i        (reset),
        .s_awaddr_i     (awaddr),
        .s_awvalid_i    (awvalid),
        .s_awready_o    (awready),
        .s_wdata_i      (wdata),
        .s_wstrb_i      (wstrb),
        .s_wvalid_i     (wvalid),
        .s_wready_o     (wready),
        .s_bresp_o      (bresp),
        .s_bvalid_o     (bvalid),
        .s_bready_i     (bready),
        .s_araddr_i     (araddr),
        .s_arvalid_i    (arvalid),
        .s_arready_o    (arready),
        .s_rdata_o      (rdata),
        .s_rresp_o      (rresp),
        .s_rvalid_o     (rvalid),
        .s_rready_i     (rready),
        .leds_o         (leds),
        .dip_switches_i (dip_switches)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("FAIL %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got,
                              input logic [1:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("FAIL %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // Byte-enable merge of a write into a stored word
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++)
        begin
            if (strb[b])
                result[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return result;
    endfunction

    // ----------------------------------------
    // AXI4-Lite driver tasks, entered on a falling edge
    // ----------------------------------------
    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int stall,
                              output logic [1:0] resp);
        int   n;
        logic aw_hs;
        logic w_hs;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        n = 0;
        while ((awvalid || wvalid) && n < TIMEOUT)
        begin
            aw_hs = awvalid && awready; // Transfer on the coming rising edge
            w_hs  = wvalid && wready;
            @(negedge clk);
            if (aw_hs)
                awvalid = 1'b0;
            if (w_hs)
                wvalid = 1'b0;
            n++;
        end
        if (awvalid || wvalid)
        begin
            $display("Timeout: write address or data not accepted at %h", addr);
            timeouts++;
            awvalid = 1'b0;
            wvalid  = 1'b0;
        end
        n = 0;
        while (!bvalid && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        resp = 2'b11;
        if (!bvalid)
        begin
            $display("Timeout: no write response for address %h", addr);
            timeouts++;
        end
        else
        begin
            repeat (stall) @(negedge clk); // Master holds off the response
            resp   = bresp;
            bready = 1'b1;
            @(negedge clk);
            bready = 1'b0;
        end
    endtask

    task automatic axil_read(input logic [15:0] addr, input int stall,
                             output logic [31:0] data, output logic [1:0] resp);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!arready)
        begin
            $display("Timeout: read address not accepted at %h", addr);
            timeouts++;
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        data = 32'h0;
        resp = 2'b11;
        if (!rvalid)
        begin
            $display("Timeout: no read response for address %h", addr);
            timeouts++;
        end
        else
        begin
            repeat (stall) @(negedge clk);
            data   = rdata;
            resp   = rresp;
            rready = 1'b1;
            @(negedge clk);
            rready = 1'b0;
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial
    begin : stimulus
        logic [1:0]  resp;
        logic [31:0] data;
        logic [31:0] got;
        logic [3:0]  strb;
        logic [7:0]  idx;
        logic [7:0]  leds_exp;
        logic [3:0]  region;
        int          i;
        int          stall;

        reset        = 1'b1;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        dip_switches = 8'h5a;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        check_val("leds_o", {24'h0, leds}, 32'h0);
        check_val("s_bvalid_o", {31'h0, bvalid}, 32'h0);
        check_val("s_rvalid_o", {31'h0, rvalid}, 32'h0);
        check_val("s_awready_o", {31'h0, awready}, 32'h1);
        check_val("s_wready_o", {31'h0, wready}, 32'h1);
        check_val("s_arready_o", {31'h0, arready}, 32'h1);

        // Boot RAM with random strobes, then the 1 KB alias
        for (i = 0; i < 8; i++)
        begin
            idx  = 8'($random(seed));
            data = $random(seed);
            axil_write({4'h0, 2'b00, idx, 2'b00}, data, 4'hf, 0, resp);
            ram_model[idx] = data;
            data = $random(seed);
            strb = 4'($random(seed));
            axil_write({4'h0, 2'b00, idx, 2'b00}, data, strb, 0, resp);
            check_resp("s_bresp_o", resp, periph_pkg::RESP_OKAY);
            ram_model[idx] = merge_bytes(ram_model[idx], data, strb);
            axil_read({4'h0, 2'b00, idx, 2'b00}, 0, got, resp);
            check_val("s_rdata_o", got, ram_model[idx]);
            check_resp("s_rresp_o", resp, periph_pkg::RESP_OKAY);
            axil_read({4'h0, 2'b01, idx, 2'b00}, 0, got, resp);
            check_val("s_rdata_o", got, ram_model[idx]);
        end

        // GPIO LEDs, readback and switches
        data = $random(seed);
        axil_write(16'h1000, data, 4'hf, 0, resp);
        leds_exp = data[7:0];
        check_resp("s_bresp_o", resp, periph_pkg::RESP_OKAY);
        check_val("leds_o", {24'h0, leds}, {24'h0, leds_exp});
        axil_read(16'h1004, 0, got, resp);
        check_val("s_rdata_o", got, {24'h0, leds_exp});
        dip_switches = 8'($random(seed));
        axil_read(16'h1000, 0, got, resp);
        check_val("s_rdata_o", got, {24'h0, dip_switches});
        axil_write(16'h1000, ~data, 4'b1110, 0, resp); // Byte 0 off
        check_val("leds_o", {24'h0, leds}, {24'h0, leds_exp});

        // Undefined GPIO offset
        axil_read(16'h1008, 0, got, resp);
        check_val("s_rdata_o", got, periph_pkg::FILLER_WORD);
        check_resp("s_rresp_o", resp, periph_pkg::RESP_OKAY);

        // Absent and unmapped regions
        for (i = 0; i < 3; i++)
        begin
            region = (i == 0) ? 4'h2 : (i == 1) ? 4'h3 : 4'hf;
            axil_write({region, 2'b00, idx, 2'b00}, $random(seed), 4'hf, 0, resp);
            check_resp("s_bresp_o", resp, periph_pkg::RESP_SLVERR);
            axil_read({region, 2'b00, idx, 2'b00}, 0, got, resp);
            check_val("s_rdata_o", got, periph_pkg::FILLER_WORD);
            check_resp("s_rresp_o", resp, periph_pkg::RESP_SLVERR);
        end
        axil_read({4'h0, 2'b00, idx, 2'b00}, 0, got, resp);
        check_val("s_rdata_o", got, ram_model[idx]);
        check_val("leds_o", {24'h0, leds}, {24'h0, leds_exp});

        // Back-pressure on B and R
        for (i = 0; i < 4; i++)
        begin
            stall = ($random(seed) & 7) + 1;
            idx   = 8'($random(seed));
            data  = $random(seed);
            axil_write({4'h0, 2'b00, idx, 2'b00}, data, 4'hf, stall, resp);
            ram_model[idx] = data;
            check_resp("s_bresp_o", resp, periph_pkg::RESP_OKAY);
            stall = ($random(seed) & 7) + 1;
            axil_read({4'h0, 2'b00, idx, 2'b00}, stall, got, resp);
            check_val("s_rdata_o", got, ram_model[idx]);
            check_resp("s_rresp_o", resp, periph_pkg::RESP_OKAY);
        end
        axil_read(16'h1004, 0, got, resp); // Plain access after the stalls
        check_val("s_rdata_o", got, {24'h0, leds_exp});

        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/periph_subsystem_chk.sv
// AXI4-Lite response channel assertions
// Valid holds until ready, payload stable while stalled, quiet after reset
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem_chk (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  periph_pkg::resp_t             s_bresp_o,
    input  logic                          s_bvalid_o,
    input  logic                          s_bready_i,
    input  logic [periph_pkg::DATA_W-1:0] s_rdata_o,
    input  periph_pkg::resp_t             s_rresp_o,
    input  logic                          s_rvalid_o,
    input  logic                          s_rready_i
);

    // ----------------------------------------
    // Handshake hold
    // ----------------------------------------
    b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (s_bvalid_o && !s_bready_i) |=> s_bvalid_o)
        else $error("BVALID dropped before BREADY");

    r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (s_rvalid_o && !s_rready_i) |=> s_rvalid_o)
        else $error("RVALID dropped before RREADY");

    // Payload stable while stalled
    b_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (s_bvalid_o && !s_bready_i) |=> $stable(s_bresp_o))
        else $error("BRESP changed while stalled");

    r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (s_rvalid_o && !s_rready_i) |=> ($stable(s_rresp_o) && $stable(s_rdata_o)))
        else $error("RRESP or RDATA changed while stalled");

    // No response straight out of reset
    rst_quiet: assert property (@(posedge clk_i)
        reset_i |=> (!s_bvalid_o && !s_rvalid_o))
        else $error("BVALID or RVALID high after reset");

endmodule

bind periph_subsystem periph_subsystem_chk i_periph_subsystem_chk (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .s_bresp_o  (s_bresp_o),
    .s_bvalid_o (s_bvalid_o),
    .s_bready_i (s_bready_i),
    .s_rdata_o  (s_rdata_o),
    .s_rresp_o  (s_rresp_o),
    .s_rvalid_o (s_rvalid_o),
    .s_rready_i (s_rready_i)
);

`default_nettype wire

//--- source/periph_subsystem.sv
// Peripheral subsystem top
// AXI4-Lite front end, region router, boot RAM and GPIO block
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic [periph_pkg::ADDR_W-1:0]     s_awaddr_i,
    input  logic                              s_awvalid_i,
    output logic                              s_awready_o,
    input  logic [periph_pkg::DATA_W-1:0]     s_wdata_i,
    input  logic [periph_pkg::STRB_W-1:0]     s_wstrb_i,
    input  logic                              s_wvalid_i,
    output logic                              s_wready_o,
    output periph_pkg::resp_t                 s_bresp_o,
    output logic                              s_bvalid_o,
    input  logic                              s_bready_i,
    input  logic [periph_pkg::ADDR_W-1:0]     s_araddr_i,
    input  logic                              s_arvalid_i,
    output logic                              s_arready_o,
    output logic [periph_pkg::DATA_W-1:0]     s_rdata_o,
    output periph_pkg::resp_t                 s_rresp_o,
    output logic                              s_rvalid_o,
    input  logic                              s_rready_i,
    output logic [periph_pkg::LED_W-1:0]      leds_o,
    input  logic [periph_pkg::LED_W-1:0]      dip_switches_i
);

    logic                          req_valid;
    periph_pkg::periph_req_t       req;
    logic                          rsp_valid;
    periph_pkg::periph_rsp_t       rsp;
    logic                          ram_sel;
    logic                          gpio_sel;
    periph_pkg::periph_req_t       tgt_req;   // Shared by both targets
    logic [periph_pkg::DATA_W-1:0] ram_rdata;
    logic [periph_pkg::DATA_W-1:0] gpio_rdata;

    axil_to_req i_axil_to_req (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .req_valid_o (req_valid),
        .req_o       (req),
        .rsp_valid_i (rsp_valid),
        .rsp_i       (rsp)
    );

    region_router i_region_router (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .ram_sel_o    (ram_sel),
        .gpio_sel_o   (gpio_sel),
        .tgt_req_o    (tgt_req),
        .ram_rdata_i  (ram_rdata),
        .gpio_rdata_i (gpio_rdata),
        .rsp_valid_o  (rsp_valid),
        .rsp_o        (rsp)
    );

    boot_ram i_boot_ram (
        .clk_i   (clk_i),
        .sel_i   (ram_sel),
        .req_i   (tgt_req),
        .rdata_o (ram_rdata)
    );

    gpio_regs i_gpio_regs (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .sel_i          (gpio_sel),
        .req_i          (tgt_req),
        .rdata_o        (gpio_rdata),
        .leds_o         (leds_o),
        .dip_switches_i (dip_switches_i)
    );

endmodule

`default_nettype wire

//--- source/gpio_regs.sv
// GPIO register block
// LED output register, DIP switch input and registered read mux
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          sel_i,
    input  periph_pkg::periph_req_t       req_i,
    output logic [periph_pkg::DATA_W-1:0] rdata_o,
    output logic [periph_pkg::LED_W-1:0]  leds_o,
    input  logic [periph_pkg::LED_W-1:0]  dip_switches_i
);

    localparam int PAD_W = periph_pkg::DATA_W - periph_pkg::LED_W;

    logic [periph_pkg::REGION_LSB-1:0] offset;
    logic                              led_wr;

    assign offset = req_i.addr[periph_pkg::REGION_LSB-1:0];

    // Only byte 0 carries LED bits
    assign led_wr = sel_i && req_i.we && req_i.strb[0] &&
                    (offset == periph_pkg::GPIO_REG_LEDS);

    // ----------------------------------------
    // LED register
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
            leds_o <= '0;
        else if (led_wr)
            leds_o <= req_i.wdata[periph_pkg::LED_W-1:0];
    end

    // Read mux
    always_ff @(posedge clk_i)
    begin
        if (sel_i)
        begin
            case (offset)
                periph_pkg::GPIO_REG_LEDS:
                    rdata_o <= {{PAD_W{1'b0}}, dip_switches_i}; // Switches on read
                periph_pkg::GPIO_REG_LED_RB:
                    rdata_o <= {{PAD_W{1'b0}}, leds_o};
                default:
                    rdata_o <= periph_pkg::FILLER_WORD;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/boot_ram.sv
// Boot RAM, 256 words
// Byte-strobe writes and registered one-cycle reads
`timescale 1ns/1ps
`default_nettype none

module boot_ram (
    input  logic                          clk_i,
    input  logic                          sel_i,
    input  periph_pkg::periph_req_t       req_i,
    output logic [periph_pkg::DATA_W-1:0] rdata_o
);

    logic [periph_pkg::DATA_W-1:0] mem [periph_pkg::RAM_WORDS];
    logic [periph_pkg::RAM_AW-1:0] idx;

    // Word index, wraps every 1 KB inside the region
    assign idx = req_i.addr[periph_pkg::RAM_AW+1:2];

    // ----------------------------------------
    // Write port
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (sel_i && req_i.we)
        begin
            for (int b = 0; b < periph_pkg::STRB_W; b++)
            begin
                if (req_i.strb[b])
                    mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
            end
        end
    end

    // Read port
    always_ff @(posedge clk_i)
    begin
        if (sel_i)
            rdata_o <= mem[idx]; // Old word on a write
    end

endmodule

`default_nettype wire

//--- source/region_router.sv
// Address region router
// Selects the boot RAM or GPIO target and muxes the response a cycle later
// Absent regions get the filler word with the error flag
`timescale 1ns/1ps
`default_nettype none

module region_router (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          req_valid_i,
    input  periph_pkg::periph_req_t       req_i,
    output logic                          ram_sel_o,
    output logic                          gpio_sel_o,
    output periph_pkg::periph_req_t       tgt_req_o,
    input  logic [periph_pkg::DATA_W-1:0] ram_rdata_i,
    input  logic [periph_pkg::DATA_W-1:0] gpio_rdata_i,
    output logic                          rsp_valid_o,
    output periph_pkg::periph_rsp_t       rsp_o
);

    logic [periph_pkg::REGION_W-1:0] region;
    logic [periph_pkg::REGION_W-1:0] region_q; // Region of the access in flight
    logic                            rsp_valid_q;

    assign region     = req_i.addr[periph_pkg::REGION_MSB:periph_pkg::REGION_LSB];
    assign ram_sel_o  = req_valid_i && (region == periph_pkg::REGION_BOOT);
    assign gpio_sel_o = req_valid_i && (region == periph_pkg::REGION_GPIO);
    assign tgt_req_o  = req_i;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
            rsp_valid_q <= 1'b0;
        else
            rsp_valid_q <= req_valid_i;
        if (req_valid_i)
            region_q <= region;
    end

    // Response mux, error responder by default
    always_comb
    begin
        rsp_o.rdata = periph_pkg::FILLER_WORD;
        rsp_o.err   = 1'b1;
        case (region_q)
            periph_pkg::REGION_BOOT:
            begin
                rsp_o.rdata = ram_rdata_i;
                rsp_o.err   = 1'b0;
            end
            periph_pkg::REGION_GPIO:
            begin
                rsp_o.rdata = gpio_rdata_i;
                rsp_o.err   = 1'b0;
            end
            periph_pkg::REGION_SPI, periph_pkg::REGION_ETH:; // No peripheral fitted
            default:;                                        // Unmapped space
        endcase
    end

    assign rsp_valid_o = rsp_valid_q;

endmodule

`default_nettype wire

//--- source/axil_to_req.sv
// AXI4-Lite slave front end
// Captures AW, W and AR, issues one internal request at a time
// and holds the B or R response until the master accepts it
`timescale 1ns/1ps
`default_nettype none

module axil_to_req (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic [periph_pkg::ADDR_W-1:0]     s_awaddr_i,
    input  logic                              s_awvalid_i,
    output logic                              s_awready_o,
    input  logic [periph_pkg::DATA_W-1:0]     s_wdata_i,
    input  logic [periph_pkg::STRB_W-1:0]     s_wstrb_i,
    input  logic                              s_wvalid_i,
    output logic                              s_wready_o,
    output periph_pkg::resp_t                 s_bresp_o,
    output logic                              s_bvalid_o,
    input  logic                              s_bready_i,
    input  logic [periph_pkg::ADDR_W-1:0]     s_araddr_i,
    input  logic                              s_arvalid_i,
    output logic                              s_arready_o,
    output logic [periph_pkg::DATA_W-1:0]     s_rdata_o,
    output periph_pkg::resp_t                 s_rresp_o,
    output logic                              s_rvalid_o,
    input  logic                              s_rready_i,
    output logic                              req_valid_o,
    output periph_pkg::periph_req_t           req_o,
    input  logic                              rsp_valid_i,
    input  periph_pkg::periph_rsp_t           rsp_i
);

    logic                          aw_done_q;
    logic                          w_done_q;
    logic                          ar_done_q;
    logic                          busy_q;     // Issued, response not yet taken
    logic                          is_write_q;
    logic                          bvalid_q;
    logic                          rvalid_q;
    logic [periph_pkg::ADDR_W-1:0] awaddr_q;
    logic [periph_pkg::ADDR_W-1:0] araddr_q;
    logic [periph_pkg::DATA_W-1:0] wdata_q;
    logic [periph_pkg::STRB_W-1:0] wstrb_q;
    logic [periph_pkg::DATA_W-1:0] rdata_q;
    periph_pkg::resp_t             resp_q;
    logic                          issue_wr;
    logic                          issue_rd;

    // ----------------------------------------
    // Channel acceptance and request issue
    // ----------------------------------------
    assign issue_wr    = !busy_q && aw_done_q && w_done_q;
    assign issue_rd    = !busy_q && ar_done_q && !issue_wr; // Write goes first
    assign req_valid_o = issue_wr || issue_rd;

    // Readies drop once captured and stay low until the response is taken
    assign s_awready_o = !busy_q && !aw_done_q && !req_valid_o;
    assign s_wready_o  = !busy_q && !w_done_q && !req_valid_o;
    assign s_arready_o = !busy_q && !ar_done_q && !req_valid_o;

    always_comb
    begin
        req_o.we    = issue_wr;
        req_o.addr  = issue_wr ? awaddr_q : araddr_q;
        req_o.wdata = wdata_q;
        req_o.strb  = issue_wr ? wstrb_q : '0;
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            aw_done_q  <= 1'b0;
            w_done_q   <= 1'b0;
            ar_done_q  <= 1'b0;
            busy_q     <= 1'b0;
            is_write_q <= 1'b0;
            bvalid_q   <= 1'b0;
            rvalid_q   <= 1'b0;
        end
        else
        begin
            if (s_awvalid_i && s_awready_o)
                aw_done_q <= 1'b1;
            if (s_wvalid_i && s_wready_o)
                w_done_q <= 1'b1;
            if (s_arvalid_i && s_arready_o)
                ar_done_q <= 1'b1;
            if (issue_wr)
            begin
                aw_done_q  <= 1'b0;
                w_done_q   <= 1'b0;
                busy_q     <= 1'b1;
                is_write_q <= 1'b1;
            end
            if (issue_rd)
            begin
                ar_done_q  <= 1'b0;
                busy_q     <= 1'b1;
                is_write_q <= 1'b0;
            end
            if (rsp_valid_i)
            begin
                bvalid_q <= is_write_q;
                rvalid_q <= !is_write_q;
            end
            if ((bvalid_q && s_bready_i) || (rvalid_q && s_rready_i))
            begin
                bvalid_q <= 1'b0;
                rvalid_q <= 1'b0;
                busy_q   <= 1'b0;
            end
        end
    end

    // Payload capture
    always_ff @(posedge clk_i)
    begin
        if (s_awvalid_i && s_awready_o)
            awaddr_q <= s_awaddr_i;
        if (s_wvalid_i && s_wready_o)
        begin
            wdata_q <= s_wdata_i;
            wstrb_q <= s_wstrb_i;
        end
        if (s_arvalid_i && s_arready_o)
            araddr_q <= s_araddr_i;
        if (rsp_valid_i)
        begin
            rdata_q <= rsp_i.rdata;
            resp_q  <= rsp_i.err ? periph_pkg::RESP_SLVERR : periph_pkg::RESP_OKAY;
        end
    end

    assign s_bvalid_o = bvalid_q;
    assign s_bresp_o  = resp_q;
    assign s_rvalid_o = rvalid_q;
    assign s_rresp_o  = resp_q;
    assign s_rdata_o  = rdata_q;

endmodule

`default_nettype wire

//--- source/periph_pkg.sv
// Peripheral subsystem package
// Bus widths, region map and GPIO register offsets
// Filler word, response codes and the internal request and response structs
`default_nettype none

package periph_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // 4 KB regions selected by the top address nibble
    localparam int REGION_MSB = 15;
    localparam int REGION_LSB = 12;
    localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

    localparam logic [REGION_W-1:0] REGION_BOOT = 4'd0;
    localparam logic [REGION_W-1:0] REGION_GPIO = 4'd1;
    localparam logic [REGION_W-1:0] REGION_SPI  = 4'd2; // Not fitted
    localparam logic [REGION_W-1:0] REGION_ETH  = 4'd3; // Not fitted

    // ----------------------------------------
    // Targets
    // ----------------------------------------
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS); // Word index bits

    localparam logic [REGION_LSB-1:0] GPIO_REG_LEDS   = 12'h000;
    localparam logic [REGION_LSB-1:0] GPIO_REG_LED_RB = 12'h004;

    localparam int LED_W = 8;

    localparam logic [DATA_W-1:0] FILLER_WORD = 32'hDEADBEEF;

    // AXI response codes
    typedef logic [1:0] resp_t;
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // One access from the bus front to a target
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;  // Byte address
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
    } periph_req_t;

    // Answer returned to the bus front
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;   // Becomes SLVERR
    } periph_rsp_t;

endpackage

`default_nettype wire
